// File: hdl/md_div.sv
// Restoring long divider for DIV and REM, one quotient bit per cycle.
// Operands are made positive first and the sign is fixed at the end.
// The remainder lives in slot 0 and the absolute denominator in slot 1.
`default_nettype none

module md_div
  import md_pkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    en_i,
  input  wire md_op_e                  operator_i,
  input  wire logic [1:0]              signed_mode_i,
  input  wire logic [md_width-1:0]     op_a_i,
  input  wire logic [md_width-1:0]     op_b_i,
  input  wire logic                    ready_i,
  input  wire logic [md_imd_width-1:0] imd_q_i,
  input  wire logic [md_width-1:0]     den_q_i,
  output logic                         imd_we_o,
  output logic      [md_imd_width-1:0] imd_d_o,
  output logic                         den_we_o,
  output logic      [md_width-1:0]     den_d_o,
  output logic                         valid_o
);

  md_div_state_e state_q, state_d;

  logic [md_cnt_width-1:0] cnt_q, cnt_d;
  logic [md_width-1:0]     numerator_q, numerator_d;
  logic [md_width-1:0]     quotient_q, quotient_d;
  logic [md_width:0]       sub_a, sub_b, sub_res;
  logic [md_width-1:0]     one_shift;
  logic [md_width-1:0]     next_remainder;
  logic [md_width-1:0]     next_quotient;
  logic                    is_greater_equal;
  logic                    sign_a, sign_b;
  logic                    div_by_zero;
  logic                    hold;
  logic                    en_int;

  assign en_int = en_i & ~hold;

  assign sign_a      = signed_mode_i[0] & op_a_i[md_width-1];
  assign sign_b      = signed_mode_i[1] & op_b_i[md_width-1];
  assign div_by_zero = (op_b_i == '0);

  // Shared subtractor for negation and the trial step
  assign sub_res = sub_a - sub_b;

  // Remainder stays below twice the denominator, so bit 32 is the borrow
  assign is_greater_equal = ~sub_res[md_width];
  assign next_remainder   = is_greater_equal ? sub_res[md_width-1:0]
                                             : imd_q_i[md_width-1:0];
  assign one_shift        = {{(md_width-1){1'b0}}, 1'b1} << cnt_q;
  assign next_quotient    = is_greater_equal ? (quotient_q | one_shift) : quotient_q;

  always_comb begin
    state_d     = state_q;
    cnt_d       = cnt_q - 1'b1;
    numerator_d = numerator_q;
    quotient_d  = quotient_q;
    imd_d_o     = imd_q_i;
    sub_a       = '0;
    sub_b       = {1'b0, op_b_i};
    valid_o     = 1'b0;
    hold        = 1'b0;

    unique case (state_q)
      MD_IDLE: begin
        // Preload the divide-by-zero answer
        if (operator_i == MD_OP_DIV) begin
          imd_d_o = '1;
        end else begin
          imd_d_o = {2'b00, op_a_i};
        end
        cnt_d   = '1;
        state_d = div_by_zero ? MD_FINISH : MD_ABS_A;
      end

      MD_ABS_A: begin
        sub_b       = {1'b0, op_a_i};
        numerator_d = sign_a ? sub_res[md_width-1:0] : op_a_i;
        quotient_d  = '0;
        cnt_d       = '1;
        state_d     = MD_ABS_B;
      end

      MD_ABS_B: begin
        // Denominator goes to slot 1 from den_d_o
        imd_d_o = {{(md_imd_width-1){1'b0}}, numerator_q[md_width-1]};
        cnt_d   = '1;
        state_d = MD_COMP;
      end

      MD_COMP: begin
        sub_a      = imd_q_i[md_width:0];
        sub_b      = {1'b0, den_q_i};
        imd_d_o    = {1'b0, next_remainder, numerator_q[cnt_d]};
        quotient_d = next_quotient;
        state_d    = (cnt_q == 1) ? MD_LAST : MD_COMP;
      end

      MD_LAST: begin
        sub_a = imd_q_i[md_width:0];
        sub_b = {1'b0, den_q_i};
        if (operator_i == MD_OP_DIV) begin
          imd_d_o = {2'b00, next_quotient};
        end else begin
          imd_d_o = {2'b00, next_remainder};
        end
        state_d = MD_CHANGE_SIGN;
      end

      MD_CHANGE_SIGN: begin
        // Quotient negative on sign mismatch, remainder follows the dividend
        sub_b = {1'b0, imd_q_i[md_width-1:0]};
        if ((operator_i == MD_OP_DIV) ? (sign_a ^ sign_b) : sign_a) begin
          imd_d_o = {2'b00, sub_res[md_width-1:0]};
        end
        state_d = MD_FINISH;
      end

      MD_FINISH: begin
        valid_o = 1'b1;
        hold    = ~ready_i;
        state_d = MD_IDLE;
      end

      default: begin
        state_d = MD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MD_IDLE;
      cnt_q   <= '0;
    end else if (en_int) begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_int) begin
      numerator_q <= numerator_d;
      quotient_q  <= quotient_d;
    end
  end

  assign imd_we_o = en_int;
  assign den_we_o = en_int && (state_q == MD_ABS_B);
  assign den_d_o  = sign_b ? sub_res[md_width-1:0] : op_b_i;

  a_state_legal : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {MD_IDLE, MD_ABS_A, MD_ABS_B, MD_COMP, MD_LAST, MD_CHANGE_SIGN,
                    MD_FINISH}
  );

  // Counter runs 31 down to 1 across the compare steps
  a_comp_cnt : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q == MD_COMP |-> cnt_q != '0
  );

endmodule

`default_nettype wire

// File: hdl/md_imd_regs.sv
// Intermediate-value registers shared by the multiplier and the divider.
// Slot 0 is the accumulator or remainder, slot 1 the absolute denominator.
`default_nettype none

module md_imd_regs
  import md_pkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    mult_we_i,
  input  wire logic [md_imd_width-1:0] mult_d_i,
  input  wire logic                    div_we_i,
  input  wire logic [md_imd_width-1:0] div_d_i,
  input  wire logic                    den_we_i,
  input  wire logic [md_width-1:0]     den_d_i,
  output logic      [md_imd_width-1:0] imd_q_o,
  output logic      [md_width-1:0]     den_q_o
);

  logic [md_imd_width-1:0] imd_q;
  logic [md_width-1:0]     den_q;

  // Only one unit is active at a time, so slot 0 takes whoever writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      imd_q <= '0;
    end else if (mult_we_i) begin
      imd_q <= mult_d_i;
    end else if (div_we_i) begin
      imd_q <= div_d_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      den_q <= '0;
    end else if (den_we_i) begin
      den_q <= den_d_i;
    end
  end

  assign imd_q_o = imd_q;
  assign den_q_o = den_q;

  // The two units must never be enabled together
  a_single_writer : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(mult_we_i && div_we_i)
  );

endmodule

`default_nettype wire

// File: hdl/md_mult.sv
// Multi-cycle multiplier for MUL and MULH on one 17x17 signed MAC.
// MUL takes three partial products, MULH four, summed through slot 0.
`default_nettype none

module md_mult
  import md_pkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    en_i,
  input  wire md_op_e                  operator_i,
  input  wire logic [1:0]              signed_mode_i,
  input  wire logic [md_width-1:0]     op_a_i,
  input  wire logic [md_width-1:0]     op_b_i,
  input  wire logic                    ready_i,
  input  wire logic [md_imd_width-1:0] imd_q_i,
  output logic                         imd_we_o,
  output logic      [md_imd_width-1:0] imd_d_o,
  output logic      [md_width-1:0]     result_o,
  output logic                         valid_o
);

  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  mult_state_e state_q, state_d;

  logic [md_half-1:0]      mult_op_a;
  logic [md_half-1:0]      mult_op_b;
  logic                    sign_a;
  logic                    sign_b;
  logic [md_imd_width-1:0] accum;
  logic [md_imd_width-1:0] mac_res;
  logic [md_imd_width-1:0] mac_res_d;
  logic                    signed_mult;
  logic                    hold;
  logic                    en_int;

  assign signed_mult = (signed_mode_i != 2'b00);
  assign en_int      = en_i & ~hold;

  // Top carry bit is always a copy of bit 33 and is dropped
  assign mac_res = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b})
                   + $signed(accum);

  always_comb begin
    mult_op_a = op_a_i[md_half-1:0];
    mult_op_b = op_b_i[md_half-1:0];
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    accum     = '0;
    mac_res_d = mac_res;
    state_d   = state_q;
    valid_o   = 1'b0;
    hold      = 1'b0;

    unique case (state_q)
      ALBL: begin
        state_d = ALBH;
      end

      ALBH: begin
        // al*bh, aligned at bit 16
        mult_op_b = op_b_i[md_width-1:md_half];
        sign_b    = signed_mode_i[1] & op_b_i[md_width-1];
        accum     = {{(md_imd_width-md_half){1'b0}}, imd_q_i[md_width-1:md_half]};
        if (operator_i == MD_OP_MULL) begin
          mac_res_d = {2'b00, mac_res[md_half-1:0], imd_q_i[md_half-1:0]};
        end
        state_d = AHBL;
      end

      AHBL: begin
        // ah*bl, aligned at bit 16
        mult_op_a = op_a_i[md_width-1:md_half];
        sign_a    = signed_mode_i[0] & op_a_i[md_width-1];
        if (operator_i == MD_OP_MULL) begin
          accum     = {{(md_imd_width-md_half){1'b0}}, imd_q_i[md_width-1:md_half]};
          mac_res_d = {2'b00, mac_res[md_half-1:0], imd_q_i[md_half-1:0]};
          valid_o   = 1'b1;
          hold      = ~ready_i;
          state_d   = ALBL;
        end else begin
          accum   = imd_q_i;
          state_d = AHBH;
        end
      end

      AHBH: begin
        // ah*bh plus the carried-down sum, MULH only
        mult_op_a = op_a_i[md_width-1:md_half];
        mult_op_b = op_b_i[md_width-1:md_half];
        sign_a    = signed_mode_i[0] & op_a_i[md_width-1];
        sign_b    = signed_mode_i[1] & op_b_i[md_width-1];
        accum     = {{md_half{signed_mult & imd_q_i[md_imd_width-1]}},
                     imd_q_i[md_imd_width-1:md_half]};
        valid_o   = 1'b1;
        hold      = ~ready_i;
        state_d   = ALBL;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
    end else if (en_int) begin
      state_q <= state_d;
    end
  end

  assign imd_we_o = en_int;
  assign imd_d_o  = mac_res_d;
  assign result_o = mac_res_d[md_width-1:0];

  // A stalled result must not move until the consumer takes it
  a_hold_stall : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> $stable(state_q) && $stable(result_o)
  );

endmodule

`default_nettype wire

// File: hdl/md_pkg.sv
// Shared widths and encodings for the multiply/divide unit.
// Imported by every RTL module and by the testbench.
`default_nettype none

package md_pkg;

  // Operand and result width
  localparam int unsigned md_width = 32;

  // Half-word slice fed to the 17x17 multiplier
  localparam int unsigned md_half = 16;

  // Accumulator width with room for carry and sign
  localparam int unsigned md_imd_width = 34;

  // Division step counter
  localparam int unsigned md_cnt_width = 5;

  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Long division sequence, one state per cycle except MD_COMP
  typedef enum logic [2:0] {
    MD_IDLE,
    MD_ABS_A,
    MD_ABS_B,
    MD_COMP,
    MD_LAST,
    MD_CHANGE_SIGN,
    MD_FINISH
  } md_div_state_e;

endpackage

`default_nettype wire

// File: hdl/md_top.sv
// Top level of the RV32M multiply/divide unit.
// The consumer holds an enable and operands until valid_o and ready_i meet.
`default_nettype none

module md_top
  import md_pkg::*;
(
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                mult_en_i,
  input  wire logic                div_en_i,
  input  wire md_op_e              operator_i,
  input  wire logic [1:0]          signed_mode_i,
  input  wire logic [md_width-1:0] op_a_i,
  input  wire logic [md_width-1:0] op_b_i,
  input  wire logic                ready_i,
  output logic      [md_width-1:0] result_o,
  output logic                     valid_o
);

  logic                    mult_we, div_we, den_we;
  logic [md_imd_width-1:0] mult_d, div_d, imd_q;
  logic [md_width-1:0]     den_d, den_q;
  logic [md_width-1:0]     mult_result;
  logic                    mult_valid, div_valid;

  md_mult u_mult (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (mult_en_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .ready_i       (ready_i),
    .imd_q_i       (imd_q),
    .imd_we_o      (mult_we),
    .imd_d_o       (mult_d),
    .result_o      (mult_result),
    .valid_o       (mult_valid)
  );

  md_div u_div (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (div_en_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .ready_i       (ready_i),
    .imd_q_i       (imd_q),
    .den_q_i       (den_q),
    .imd_we_o      (div_we),
    .imd_d_o       (div_d),
    .den_we_o      (den_we),
    .den_d_o       (den_d),
    .valid_o       (div_valid)
  );

  md_imd_regs u_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mult_we_i (mult_we),
    .mult_d_i  (mult_d),
    .div_we_i  (div_we),
    .div_d_i   (div_d),
    .den_we_i  (den_we),
    .den_d_i   (den_d),
    .imd_q_o   (imd_q),
    .den_q_o   (den_q)
  );

  // Divider result sits in slot 0 once it reaches MD_FINISH
  assign valid_o  = mult_valid | div_valid;
  assign result_o = div_valid ? imd_q[md_width-1:0] : mult_result;

  // A new division may only begin from an idle divider
  a_div_start_idle : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(div_en_i) |-> u_div.state_q == MD_IDLE
  );

endmodule

`default_nettype wire

// File: multdiv.f
+incdir+include
hdl/md_pkg.sv
hdl/md_imd_regs.sv
hdl/md_mult.sv
hdl/md_div.sv
hdl/md_top.sv
sim/md_tb.sv

// File: include/md_ref_model.svh
// Reference results for the testbench, one call per operation.
// Include inside a module that imports md_pkg.
`ifndef MD_REF_MODEL_SVH
`define MD_REF_MODEL_SVH

function automatic logic [31:0] md_ref_result(input md_op_e op, input logic [1:0] sm,
                                              input logic [31:0] a, input logic [31:0] b);
  logic signed [32:0] ea;
  logic signed [32:0] eb;
  logic signed [65:0] prod;
  logic signed [33:0] quot;
  logic signed [33:0] rem;
  ea   = $signed({sm[0] & a[31], a});
  eb   = $signed({sm[1] & b[31], b});
  prod = ea * eb;
  if (op == MD_OP_MULL) begin
    return prod[31:0];
  end else if (op == MD_OP_MULH) begin
    return prod[63:32];
  end else if (b == '0) begin
    // RISC-V results for a zero divisor
    return (op == MD_OP_DIV) ? 32'hffff_ffff : a;
  end
  // Wide operands keep min / -1 from overflowing
  quot = 34'(ea) / 34'(eb);
  rem  = 34'(ea) % 34'(eb);
  return (op == MD_OP_DIV) ? quot[31:0] : rem[31:0];
endfunction

`endif

// File: sim/md_tb.sv
// Seeded random testbench for the multiply/divide unit.
// Runs MUL, MULH, DIV and REM with random stalls and checks results and latency.
`default_nettype none

module md_tb
  import md_pkg::*;
();

  `include "md_ref_model.svh"

  localparam int num_tests = 200;
  localparam int wd_margin = 4000;

  logic              clk_i;
  logic              rst_ni;
  logic              mult_en_i;
  logic              div_en_i;
  md_op_e            operator_i;
  logic [1:0]        signed_mode_i;
  logic [31:0]       op_a_i;
  logic [31:0]       op_b_i;
  logic              ready_i;
  logic [31:0]       result_o;
  logic              valid_o;

  integer            seed = 89;
  int                pass_cnt = 0;
  int                fail_cnt = 0;
  integer            rnd;
  md_op_e            op;
  logic [1:0]        sm;
  logic [31:0]       a;
  logic [31:0]       b;
  int                stall;

  md_top dut0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mult_en_i     (mult_en_i),
    .div_en_i      (div_en_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .ready_i       (ready_i),
    .result_o      (result_o),
    .valid_o       (valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Cycle of the enable in which valid_o first rises
  function automatic int expected_latency(input md_op_e o, input logic [31:0] divisor);
    if (o == MD_OP_MULL) begin
      return 3;
    end else if (o == MD_OP_MULH) begin
      return 4;
    end
    return (divisor == '0) ? 2 : 37;
  endfunction

  task automatic record_result(input string name, input bit ok);
    if (ok) begin
      pass_cnt++;
      $display("%s: pass", name);
    end else begin
      fail_cnt++;
      $display("%s: FAIL", name);
    end
  endtask

  task automatic check_reset();
    bit ok = 1'b1;
    repeat (8) begin
      @(negedge clk_i);
      assert (!valid_o) else begin
        $display("reset: valid_o is high while rst_ni is low");
        ok = 1'b0;
      end
    end
    @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    assert (!valid_o) else begin
      $display("reset: valid_o is high on the first cycle after reset");
      ok = 1'b0;
    end
    record_result("reset", ok);
  endtask

  task automatic run_op(input int t, input md_op_e o, input logic [1:0] mode,
                        input logic [31:0] opa, input logic [31:0] opb, input int stall_cyc);
    string       name;
    logic [31:0] exp_res;
    int          exp_cyc;
    int          cyc;
    bit          ok;
    name    = $sformatf("t%0d_%s", t, o.name());
    exp_res = md_ref_result(o, mode, opa, opb);
    exp_cyc = expected_latency(o, opb);
    ok      = 1'b1;
    @(posedge clk_i);
    #1;
    operator_i    = o;
    signed_mode_i = mode;
    op_a_i        = opa;
    op_b_i        = opb;
    ready_i       = (stall_cyc == 0);
    mult_en_i     = (o == MD_OP_MULL) || (o == MD_OP_MULH);
    div_en_i      = (o == MD_OP_DIV) || (o == MD_OP_REM);
    cyc = 0;
    do begin
      @(negedge clk_i);
      cyc++;
    end while (!valid_o && cyc < 60);
    assert (valid_o) else begin
      $display("%s: valid_o never rose", name);
      ok = 1'b0;
    end
    if (valid_o) begin
      assert (cyc == exp_cyc) else begin
        $display("ERR %s latency: expected %0d, actual %0d", name, exp_cyc, cyc);
        ok = 1'b0;
      end
      assert (result_o == exp_res) else begin
        $display("ERR %s: expected %h, actual %h", name, exp_res, result_o);
        ok = 1'b0;
      end
      // Result must sit still while the consumer stalls
      for (int i = 1; i <= stall_cyc; i++) begin
        @(posedge clk_i);
        #1;
        if (i == stall_cyc) begin
          ready_i = 1'b1;
        end
        @(negedge clk_i);
        assert (valid_o) else begin
          $display("%s: valid_o dropped while ready_i was low", name);
          ok = 1'b0;
        end
        assert (result_o == exp_res) else begin
          $display("ERR %s stall %0d: expected %h, actual %h", name, i, exp_res, result_o);
          ok = 1'b0;
        end
      end
    end
    // Accepting edge
    @(posedge clk_i);
    #1;
    mult_en_i = 1'b0;
    div_en_i  = 1'b0;
    ready_i   = 1'b0;
    record_result(name, ok);
  endtask

  initial begin
    rst_ni        = 1'b0;
    mult_en_i     = 1'b0;
    div_en_i      = 1'b0;
    ready_i       = 1'b0;
    operator_i    = MD_OP_MULL;
    signed_mode_i = 2'b00;
    op_a_i        = '0;
    op_b_i        = '0;
    check_reset();
    for (int t = 0; t < num_tests; t++) begin
      rnd   = $random(seed);
      op    = md_op_e'(rnd[1:0]);
      sm    = rnd[3:2];
      a     = $random(seed);
      b     = $random(seed);
      stall = $random(seed) & 3;
      if ((op == MD_OP_DIV || op == MD_OP_REM) && (($random(seed) & 7) == 0)) begin
        b = '0;
      end
      // Signed overflow corner first
      if (t < 2) begin
        op = (t == 0) ? MD_OP_DIV : MD_OP_REM;
        sm = 2'b11;
        a  = 32'h8000_0000;
        b  = 32'hffff_ffff;
      end
      run_op(t, op, sm, a, b, stall);
    end
    $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the longest operation
  initial begin
    #(num_tests * 40 * 4 + wd_margin);
    $display("Watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
